// ==== rtl/cpu.sv ====
module cpu
    import lc3b_pkg::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  lc3b_word mem_rdata,
    input  logic     mem_resp,
    output logic     mem_request,
    output logic     mem_read_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata
);

    lc3b_ctrl   ctrl;
    lc3b_opcode opcode;
    logic       inst5;
    logic       branch_enable;

    cpu_control cpu_control_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_resp       (mem_resp),
        .ctrl           (ctrl),
        .mem_request    (mem_request),
        .mem_read_write (mem_read_write)
    );

    // Registers, ALU and muxes
    cpu_datapath #(
        .reset_pc (reset_pc)
    ) cpu_datapath_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .mem_rdata     (mem_rdata),
        .opcode        (opcode),
        .inst5         (inst5),
        .branch_enable (branch_enable),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata)
    );

endmodule

// ==== rtl/cpu_control.sv ====
module cpu_control
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  lc3b_opcode opcode,
    input  logic       inst5,
    input  logic       branch_enable,
    input  logic       mem_resp,
    output lc3b_ctrl   ctrl,
    output logic       mem_request,
    output logic       mem_read_write
);

    cpu_state_t state;
    cpu_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;

        case (state)
            s_fetch1: begin
                next_state = s_fetch2;
            end

            // Wait for the instruction word
            s_fetch2: begin
                if (mem_resp) begin
                    next_state = s_fetch3;
                end
            end

            s_fetch3: begin
                next_state = s_decode;
            end

            s_decode: begin
                case (opcode)
                    op_add:  next_state = s_add;
                    op_and:  next_state = s_and;
                    op_not:  next_state = s_not;
                    op_br:   next_state = s_br;
                    op_jmp:  next_state = s_jmp;
                    op_lea:  next_state = s_lea;
                    op_ldr:  next_state = s_calc_addr;
                    op_str:  next_state = s_calc_addr;
                    // Unsupported opcodes run as no-ops
                    default: next_state = s_fetch1;
                endcase
            end

            s_br: begin
                if (branch_enable) begin
                    next_state = s_br_taken;
                end else begin
                    next_state = s_fetch1;
                end
            end

            s_calc_addr: begin
                if (opcode == op_ldr) begin
                    next_state = s_ldr1;
                end else begin
                    next_state = s_str1;
                end
            end

            s_ldr1: begin
                if (mem_resp) begin
                    next_state = s_ldr2;
                end
            end

            s_str1: begin
                next_state = s_str2;
            end

            s_str2: begin
                if (mem_resp) begin
                    next_state = s_fetch1;
                end
            end

            // Single-cycle execute states
            default: begin
                next_state = s_fetch1;
            end
        endcase
    end

    always_comb begin
        ctrl.load_pc        = 1'b0;
        ctrl.load_ir        = 1'b0;
        ctrl.load_regfile   = 1'b0;
        ctrl.load_mar       = 1'b0;
        ctrl.load_mdr       = 1'b0;
        ctrl.load_cc        = 1'b0;
        ctrl.pcmux_sel      = pcmux_pc_plus2;
        ctrl.alumux_sel     = alumux_sr2;
        ctrl.regfilemux_sel = regfilemux_alu;
        ctrl.marmux_sel     = marmux_alu;
        ctrl.mdrmux_sel     = mdrmux_alu;
        ctrl.storemux_sel   = storemux_sr1;
        ctrl.aluop          = alu_add;
        mem_request         = 1'b0;
        mem_read_write      = 1'b0;

        case (state)
            // MAR <- PC, PC <- PC + 2
            s_fetch1: begin
                ctrl.marmux_sel = marmux_pc;
                ctrl.load_mar   = 1'b1;
                ctrl.pcmux_sel  = pcmux_pc_plus2;
                ctrl.load_pc    = 1'b1;
            end

            // MDR <- M[MAR]
            s_fetch2, s_ldr1: begin
                mem_request     = 1'b1;
                ctrl.mdrmux_sel = mdrmux_mem;
                ctrl.load_mdr   = 1'b1;
            end

            s_fetch3: begin
                ctrl.load_ir = 1'b1;
            end

            s_add, s_and: begin
                if (inst5) begin
                    ctrl.alumux_sel = alumux_imm5;
                end else begin
                    ctrl.alumux_sel = alumux_sr2;
                end
                ctrl.aluop        = (state == s_add) ? alu_add : alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end

            s_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end

            // PC already holds the incremented value here
            s_br_taken: begin
                ctrl.pcmux_sel = pcmux_pc_offset9;
                ctrl.load_pc   = 1'b1;
            end

            s_jmp: begin
                ctrl.pcmux_sel = pcmux_base_reg;
                ctrl.load_pc   = 1'b1;
            end

            s_lea: begin
                ctrl.regfilemux_sel = regfilemux_pc_offset9;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end

            // MAR <- base + sext(offset6) << 1
            s_calc_addr: begin
                ctrl.alumux_sel = alumux_offset6;
                ctrl.aluop      = alu_add;
                ctrl.marmux_sel = marmux_alu;
                ctrl.load_mar   = 1'b1;
            end

            s_ldr2: begin
                ctrl.regfilemux_sel = regfilemux_mdr;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end

            // MDR <- SR, read through the destination field
            s_str1: begin
                ctrl.storemux_sel = storemux_dest;
                ctrl.aluop        = alu_pass;
                ctrl.mdrmux_sel   = mdrmux_alu;
                ctrl.load_mdr     = 1'b1;
            end

            s_str2: begin
                mem_request    = 1'b1;
                mem_read_write = 1'b1;
            end

            // Decode and untaken branch only wait a cycle
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/cpu_datapath.sv ====
module cpu_datapath
    import lc3b_pkg::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  lc3b_ctrl   ctrl,
    input  lc3b_word   mem_rdata,
    output lc3b_opcode opcode,
    output logic       inst5,
    output logic       branch_enable,
    output lc3b_word   mem_address,
    output lc3b_word   mem_wdata
);

    lc3b_word pc;
    lc3b_word ir;
    lc3b_word mar;
    lc3b_word mdr;
    logic [2:0] cc;

    lc3b_reg  sr1_idx;
    lc3b_word reg_a;
    lc3b_word reg_b;

    lc3b_word pc_plus2;
    lc3b_word pc_offset9;
    lc3b_word sext_imm5;
    lc3b_word sext_offset6;
    lc3b_word pcmux_out;
    lc3b_word alumux_out;
    lc3b_word alu_out;
    lc3b_word regfilemux_out;
    lc3b_word marmux_out;
    lc3b_word mdrmux_out;
    logic [2:0] new_cc;

    // Immediate fields of the instruction
    assign sext_imm5    = {{11{ir[4]}}, ir[4:0]};
    assign sext_offset6 = {{9{ir[5]}}, ir[5:0], 1'b0};

    assign pc_plus2   = pc + 16'd2;
    assign pc_offset9 = pc + {{6{ir[8]}}, ir[8:0], 1'b0};

    assign sr1_idx = (ctrl.storemux_sel == storemux_dest) ? ir[11:9] : ir[8:6];

    regfile regfile_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ctrl.load_regfile),
        .src_a (sr1_idx),
        .src_b (ir[2:0]),
        .dest  (ir[11:9]),
        .in    (regfilemux_out),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_comb begin
        case (ctrl.alumux_sel)
            alumux_imm5:    alumux_out = sext_imm5;
            alumux_offset6: alumux_out = sext_offset6;
            default:        alumux_out = reg_b;
        endcase
    end

    always_comb begin
        case (ctrl.aluop)
            alu_add: alu_out = reg_a + alumux_out;
            alu_and: alu_out = reg_a & alumux_out;
            alu_not: alu_out = ~reg_a;
            default: alu_out = reg_a;
        endcase
    end

    always_comb begin
        case (ctrl.regfilemux_sel)
            regfilemux_mdr:        regfilemux_out = mdr;
            regfilemux_pc_offset9: regfilemux_out = pc_offset9;
            default:               regfilemux_out = alu_out;
        endcase
    end

    always_comb begin
        case (ctrl.pcmux_sel)
            pcmux_pc_offset9: pcmux_out = pc_offset9;
            pcmux_base_reg:   pcmux_out = reg_a;
            default:          pcmux_out = pc_plus2;
        endcase
    end

    assign marmux_out = (ctrl.marmux_sel == marmux_pc) ? pc : alu_out;
    assign mdrmux_out = (ctrl.mdrmux_sel == mdrmux_mem) ? mem_rdata : alu_out;

    // NZP flags of the value going into the register file
    always_comb begin
        if (regfilemux_out[15]) begin
            new_cc = 3'b100;
        end else if (regfilemux_out == '0) begin
            new_cc = 3'b010;
        end else begin
            new_cc = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
            cc <= 3'b010;
        end else begin
            if (ctrl.load_pc) begin
                pc <= pcmux_out;
            end
            if (ctrl.load_cc) begin
                cc <= new_cc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) begin
            ir <= mdr;
        end
        if (ctrl.load_mar) begin
            mar <= marmux_out;
        end
        if (ctrl.load_mdr) begin
            mdr <= mdrmux_out;
        end
    end

    assign opcode        = ir[15:12];
    assign inst5         = ir[5];
    assign branch_enable = |(ir[11:9] & cc);

    assign mem_address = mar;
    assign mem_wdata   = mdr;

endmodule

// ==== rtl/lc3b_pkg.sv ====
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [3:0]  lc3b_opcode;
    typedef logic [1:0]  lc3b_aluop;

    // LC-3b opcode encodings of the supported instructions
    localparam lc3b_opcode op_br  = 4'b0000;
    localparam lc3b_opcode op_add = 4'b0001;
    localparam lc3b_opcode op_and = 4'b0101;
    localparam lc3b_opcode op_ldr = 4'b0110;
    localparam lc3b_opcode op_str = 4'b0111;
    localparam lc3b_opcode op_not = 4'b1001;
    localparam lc3b_opcode op_jmp = 4'b1100;
    localparam lc3b_opcode op_lea = 4'b1110;

    localparam lc3b_aluop alu_add  = 2'd0;
    localparam lc3b_aluop alu_and  = 2'd1;
    localparam lc3b_aluop alu_not  = 2'd2;
    localparam lc3b_aluop alu_pass = 2'd3;

    // Next PC source
    localparam logic [1:0] pcmux_pc_plus2   = 2'd0;
    localparam logic [1:0] pcmux_pc_offset9 = 2'd1;
    localparam logic [1:0] pcmux_base_reg   = 2'd2;

    // ALU operand B source
    localparam logic [1:0] alumux_sr2     = 2'd0;
    localparam logic [1:0] alumux_imm5    = 2'd1;
    localparam logic [1:0] alumux_offset6 = 2'd2;

    // Register file write data source
    localparam logic [1:0] regfilemux_alu        = 2'd0;
    localparam logic [1:0] regfilemux_mdr        = 2'd1;
    localparam logic [1:0] regfilemux_pc_offset9 = 2'd2;

    localparam logic marmux_alu = 1'b0;
    localparam logic marmux_pc  = 1'b1;

    localparam logic mdrmux_alu = 1'b0;
    localparam logic mdrmux_mem = 1'b1;

    // SR1 index from IR[8:6] or from the destination field IR[11:9]
    localparam logic storemux_sr1  = 1'b0;
    localparam logic storemux_dest = 1'b1;

    typedef struct packed {
        logic       load_pc;
        logic       load_ir;
        logic       load_regfile;
        logic       load_mar;
        logic       load_mdr;
        logic       load_cc;
        logic [1:0] pcmux_sel;
        logic [1:0] alumux_sel;
        logic [1:0] regfilemux_sel;
        logic       marmux_sel;
        logic       mdrmux_sel;
        logic       storemux_sel;
        lc3b_aluop  aluop;
    } lc3b_ctrl;

    typedef enum logic [3:0] {
        s_fetch1, s_fetch2, s_fetch3, s_decode,
        s_add, s_and, s_not,
        s_br, s_br_taken, s_jmp, s_lea,
        s_calc_addr, s_ldr1, s_ldr2, s_str1, s_str2
    } cpu_state_t;

endpackage

// ==== rtl/regfile.sv ====
module regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_reg  dest,
    input  lc3b_word in,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word regs [0:7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Asynchronous reads, a write shows up the cycle after
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f sim.f || exit 1

output=$(./obj_dir/Vtb_cpu 2>&1)
echo "$output"

echo "$output" | grep -qx "Finished with no errors" && exit 0 || exit 1

// ==== sim.f ====
rtl/lc3b_pkg.sv
rtl/regfile.sv
rtl/cpu_control.sv
rtl/cpu_datapath.sv
rtl/cpu.sv
testbench/cpu_props.sv
testbench/tb_cpu.sv

// ==== testbench/cpu_props.sv ====
module cpu_props
    import lc3b_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input cpu_state_t state,
    input logic       mem_request,
    input logic       mem_read_write
);

    // Memory is only requested from the three memory states
    request_in_mem_state: assert property (@(posedge clk) disable iff (!rst_n)
        mem_request |-> state inside {s_fetch2, s_ldr1, s_str2})
        else $error("mem_request high in state %s", state.name());

    write_only_in_str2: assert property (@(posedge clk) disable iff (!rst_n)
        mem_read_write |-> state == s_str2)
        else $error("mem_read_write high in state %s", state.name());

    // Every other state lasts exactly one cycle
    no_stall_outside_mem: assert property (@(posedge clk) disable iff (!rst_n)
        !(state inside {s_fetch2, s_ldr1, s_str2}) |=> state != $past(state))
        else $error("state %s held for two cycles", state.name());

    reset_to_fetch1: assert property (@(posedge clk)
        !rst_n |=> state == s_fetch1)
        else $error("state %s after reset", state.name());

endmodule

bind cpu_control cpu_props cpu_props_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .state          (state),
    .mem_request    (mem_request),
    .mem_read_write (mem_read_write)
);

// ==== testbench/tb_cpu.sv ====
module tb_cpu
    import lc3b_pkg::*;
();

    localparam int num_instr = 2000;
    localparam int req_timeout = 40;
    localparam lc3b_word reset_pc = 16'h0000;

    logic     clk;
    logic     rst_n;
    lc3b_word mem_rdata;
    logic     mem_resp;
    logic     mem_request;
    logic     mem_read_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;

    // Memory the DUT talks to, and the model's own copy
    lc3b_word mem [0:4095];
    lc3b_word ref_mem [0:4095];

    // Architectural state of the reference model
    lc3b_word   ref_pc;
    lc3b_word   ref_regs [0:7];
    logic [2:0] ref_cc;

    int check_count;
    int error_count;
    int instr_count;

    cpu #(
        .reset_pc (reset_pc)
    ) cpu_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp),
        .mem_request    (mem_request),
        .mem_read_write (mem_read_write),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

    always #10 clk = ~clk;

    function automatic lc3b_word random_instruction();
        lc3b_word word;
        word = lc3b_word'($urandom);
        case ($urandom % 8)
            0: word[15:12] = op_br;
            1: word[15:12] = op_add;
            2: word[15:12] = op_and;
            3: word[15:12] = op_not;
            4: word[15:12] = op_jmp;
            5: word[15:12] = op_ldr;
            6: word[15:12] = op_str;
            default: word[15:12] = op_lea;
        endcase
        return word;
    endfunction

    function automatic logic [2:0] nzp_of(input lc3b_word value);
        if (value[15]) begin
            return 3'b100;
        end else if (value == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    task automatic write_reg(input lc3b_reg dr, input lc3b_word value);
        ref_regs[dr] = value;
        ref_cc = nzp_of(value);
    endtask

    task automatic check_value(input string name, input lc3b_word actual,
                               input lc3b_word expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: actual 0x%h, expected 0x%h, instruction %0d",
                     name, actual, expected, instr_count);
        end
    endtask

    // Sampled on falling edges, where the combinational request is settled
    task automatic wait_request(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < req_timeout) begin
            if (mem_request) begin
                ok = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!ok) begin
            error_count++;
            $display("ERROR: no memory request within %0d cycles, instruction %0d",
                     req_timeout, instr_count);
        end
    endtask

    // Answers the pending request after 1 to 4 cycles with one mem_resp pulse
    task automatic serve_request();
        int       latency;
        lc3b_word addr;
        logic     write;
        lc3b_word wdata;
        latency = 1 + ($urandom % 4);
        addr = mem_address;
        write = mem_read_write;
        wdata = mem_wdata;
        repeat (latency - 1) begin
            @(negedge clk);
            if (!mem_request) begin
                error_count++;
                $display("ERROR: mem_request dropped before the response at %0t", $time);
            end
        end
        if (write) begin
            mem[addr[12:1]] = wdata;
        end else begin
            mem_rdata = mem[addr[12:1]];
        end
        mem_resp = 1'b1;
        @(negedge clk);
        mem_resp = 1'b0;
        if (mem_request) begin
            error_count++;
            $display("ERROR: mem_request still high after the response at %0t", $time);
        end
    endtask

    // One instruction of the model, checked against the DUT's memory traffic
    task automatic run_instruction(output bit ok);
        lc3b_word ir;
        lc3b_word next_pc;
        lc3b_word sr1;
        lc3b_word operand;
        lc3b_word offset9;
        lc3b_word offset6;
        lc3b_word addr;
        lc3b_reg  dr;

        wait_request(ok);
        if (ok) begin
            check_value("mem_read_write", lc3b_word'(mem_read_write), 16'h0000);
            check_value("mem_address", mem_address, ref_pc);
            serve_request();

            ir = ref_mem[ref_pc[12:1]];
            dr = ir[11:9];
            sr1 = ref_regs[ir[8:6]];
            offset9 = lc3b_word'($signed(ir[8:0])) << 1;
            offset6 = lc3b_word'($signed(ir[5:0])) << 1;
            operand = ir[5] ? lc3b_word'($signed(ir[4:0])) : ref_regs[ir[2:0]];
            next_pc = ref_pc + 16'd2;
            ref_pc = next_pc;

            case (ir[15:12])
                op_add: write_reg(dr, sr1 + operand);
                op_and: write_reg(dr, sr1 & operand);
                op_not: write_reg(dr, ~sr1);
                op_lea: write_reg(dr, next_pc + offset9);
                op_jmp: ref_pc = sr1;
                op_br: begin
                    if ((ir[11:9] & ref_cc) != 3'b000) begin
                        ref_pc = next_pc + offset9;
                    end
                end
                op_ldr: begin
                    addr = sr1 + offset6;
                    wait_request(ok);
                    if (ok) begin
                        check_value("mem_read_write", lc3b_word'(mem_read_write), 16'h0000);
                        check_value("mem_address", mem_address, addr);
                        serve_request();
                        write_reg(dr, ref_mem[addr[12:1]]);
                    end
                end
                op_str: begin
                    addr = sr1 + offset6;
                    wait_request(ok);
                    if (ok) begin
                        check_value("mem_read_write", lc3b_word'(mem_read_write), 16'h0001);
                        check_value("mem_address", mem_address, addr);
                        check_value("mem_wdata", mem_wdata, ref_regs[dr]);
                        serve_request();
                        ref_mem[addr[12:1]] = ref_regs[dr];
                    end
                end
                // Anything else is a no-op
                default: begin
                end
            endcase
        end
    endtask

    initial begin
        bit ok;
        clk = 1'b0;
        rst_n = 1'b0;
        mem_rdata = 16'h0000;
        mem_resp = 1'b0;
        check_count = 0;
        error_count = 0;
        instr_count = 0;
        void'($urandom(57293));

        for (int i = 0; i < 4096; i++) begin
            mem[i] = random_instruction();
            ref_mem[i] = mem[i];
        end
        for (int r = 0; r < 8; r++) begin
            ref_regs[r] = 16'h0000;
        end
        ref_pc = reset_pc;
        ref_cc = 3'b010;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        ok = 1'b1;
        while (ok && instr_count < num_instr) begin
            run_instruction(ok);
            if (ok) begin
                instr_count++;
            end
        end

        $display("Instructions: %0d, checks: %0d, errors: %0d",
                 instr_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
